//--- logic/ooo_pkg.sv
////////////////////
// shared widths, encodings and packed structs for the ALU cluster
// a tag of zero means a constant operand and is never broadcast
// one broadcast source only, no CDB arbitration
////////////////////

package ooo_pkg;

    ////////////////////
    // widths
    localparam int XLEN        = 32;  // data word
    localparam int TAG_LEN     = 6;   // physical register tag
    localparam int RS_ALU_SIZE = 4;   // station entries
    localparam int RS_ALU_LEN  = 2;   // station index

    ////////////////////
    // encodings
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,  // signed compare
        ALU_SLTU = 4'h6,  // unsigned compare
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_NPC  = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_select_t;

    typedef enum logic [1:0] {
        OPB_IS_RS2   = 2'h0,
        OPB_IS_I_IMM = 2'h1,
        OPB_IS_U_IMM = 2'h2  // 2'h3 unused
    } opb_select_t;

    ////////////////////
    // packets
    typedef struct packed {
        logic [TAG_LEN-1:0] tag;    // producer tag
        logic               ready;  // value is valid
        logic [XLEN-1:0]    value;
    } operand_t;

    typedef struct packed {
        logic               valid;
        logic [31:0]        inst;        // raw instruction word, for immediates
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    npc;
        opa_select_t        opa_select;
        opb_select_t        opb_select;
        alu_func_t          alu_func;
        operand_t           rs1;         // from rename / register file
        operand_t           rs2;
        logic [TAG_LEN-1:0] dest_tag;
    } dispatch_packet_t;

    typedef struct packed {
        operand_t           opa;
        operand_t           opb;
        alu_func_t          alu_func;
        logic [TAG_LEN-1:0] dest_tag;
        logic [XLEN-1:0]    pc;
    } rs_entry_t;

    typedef struct packed {
        logic               valid;
        logic [TAG_LEN-1:0] tag;
        logic [XLEN-1:0]    value;
    } cdb_packet_t;

endpackage

//--- logic/operand_select.sv
////////////////////
// dispatch operand select, purely combinational
// constant operands leave ready with tag zero
// register operands are passed on as given by rename
////////////////////

`timescale 1ns/1ps

module operand_select import ooo_pkg::*; (
    input  dispatch_packet_t dispatch,        // from rename
    output rs_entry_t        entry_in,        // to station
    output logic             dispatch_valid
);

    logic [XLEN-1:0] i_imm;  // sign extended
    logic [XLEN-1:0] u_imm;  // upper 20 bits

    // constant operand, always ready
    function automatic operand_t const_op(input logic [XLEN-1:0] val);
        operand_t op;
        op.tag   = '0;
        op.ready = 1'b1;
        op.value = val;
        return op;
    endfunction

    ////////////////////
    // immediate decode
    assign i_imm = {{20{dispatch.inst[31]}}, dispatch.inst[31:20]};
    assign u_imm = {dispatch.inst[31:12], 12'b0};

    // operand a mux
    always_comb begin
        case (dispatch.opa_select)
            OPA_IS_RS1:  entry_in.opa = dispatch.rs1;     // may still wait on cdb
            OPA_IS_PC:   entry_in.opa = const_op(dispatch.pc);
            OPA_IS_NPC:  entry_in.opa = const_op(dispatch.npc);
            default:     entry_in.opa = const_op('0);     // zero
        endcase
    end

    // operand b mux
    always_comb begin
        case (dispatch.opb_select)
            OPB_IS_RS2:   entry_in.opb = dispatch.rs2;
            OPB_IS_I_IMM: entry_in.opb = const_op(i_imm);
            OPB_IS_U_IMM: entry_in.opb = const_op(u_imm);
            default:      entry_in.opb = const_op('0);    // unused encoding
        endcase
    end

    // remaining fields straight from the packet
    assign entry_in.alu_func = dispatch.alu_func;
    assign entry_in.dest_tag = dispatch.dest_tag;
    assign entry_in.pc       = dispatch.pc;
    assign dispatch_valid    = dispatch.valid;

endmodule

//--- logic/rs_alu.sv
////////////////////
// four entry ALU reservation station
// no handshake, a dispatch while rs_full is dropped
// issue picks the lowest ready index, one per cycle
// commit_mis_pred empties every entry
////////////////////

`timescale 1ns/1ps

module rs_alu import ooo_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        commit_mis_pred,  // flush
    input  logic        dispatch_valid,
    input  rs_entry_t   entry_in,
    input  cdb_packet_t cdb,              // wakeup source
    output rs_entry_t   issue,            // to alu
    output logic        issue_valid,
    output logic        rs_full
);

    rs_entry_t [RS_ALU_SIZE-1:0] entries;     // stored payload
    rs_entry_t [RS_ALU_SIZE-1:0] entries_wk;  // payload after cdb wakeup
    rs_entry_t                   in_wk;       // arriving entry after wakeup
    logic [RS_ALU_SIZE-1:0]      entry_valid;
    logic [RS_ALU_LEN-1:0]       alloc_idx;
    logic [RS_ALU_LEN-1:0]       issue_idx;
    logic                        issue_any;
    logic                        alloc_en;

    // tag match against the broadcast
    function automatic operand_t wake(input operand_t op, input cdb_packet_t c);
        operand_t res;
        res = op;
        if (c.valid && !op.ready && op.tag == c.tag) begin
            res.ready = 1'b1;
            res.value = c.value;
        end
        return res;
    endfunction

    ////////////////////
    // wakeup
    always_comb begin
        for (int i = 0; i < RS_ALU_SIZE; i++) begin
            entries_wk[i]     = entries[i];
            entries_wk[i].opa = wake(entries[i].opa, cdb);
            entries_wk[i].opb = wake(entries[i].opb, cdb);
        end
        in_wk     = entry_in;
        in_wk.opa = wake(entry_in.opa, cdb);  // producer broadcasting this cycle
        in_wk.opb = wake(entry_in.opb, cdb);
    end

    ////////////////////
    // allocate and select
    assign rs_full  = &entry_valid;
    assign alloc_en = dispatch_valid && !rs_full;

    // first free slot
    always_comb begin
        alloc_idx = '0;
        for (int i = RS_ALU_SIZE - 1; i >= 0; i--) begin
            if (!entry_valid[i])
                alloc_idx = RS_ALU_LEN'(i);
        end
    end

    // lowest index with both operands stored ready
    always_comb begin
        issue_idx = '0;
        issue_any = 1'b0;
        for (int i = RS_ALU_SIZE - 1; i >= 0; i--) begin
            if (entry_valid[i] && entries[i].opa.ready && entries[i].opb.ready) begin
                issue_idx = RS_ALU_LEN'(i);
                issue_any = 1'b1;
            end
        end
    end

    ////////////////////
    // state
    always_ff @(posedge clock) begin
        if (rst || commit_mis_pred) begin
            entry_valid <= '0;
            issue_valid <= 1'b0;
        end else begin
            for (int i = 0; i < RS_ALU_SIZE; i++) begin
                if (alloc_en && alloc_idx == RS_ALU_LEN'(i))
                    entry_valid[i] <= 1'b1;
                else if (issue_any && issue_idx == RS_ALU_LEN'(i))
                    entry_valid[i] <= 1'b0;  // freed at the issue edge
            end
            issue_valid <= issue_any;
        end
    end

    // payload, written every cycle so wakeups stick
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_ALU_SIZE; i++) begin
            if (alloc_en && alloc_idx == RS_ALU_LEN'(i))
                entries[i] <= in_wk;
            else
                entries[i] <= entries_wk[i];
        end
        issue <= entries[issue_idx];
    end

endmodule

//--- logic/alu_stage.sv
////////////////////
// registered integer ALU, one cycle
// drives the single source CDB
// shifts use opb[4:0] only
////////////////////

`timescale 1ns/1ps

module alu_stage import ooo_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        commit_mis_pred,  // kills the result in flight
    input  rs_entry_t   issue,
    input  logic        issue_valid,
    output cdb_packet_t cdb
);

    logic [XLEN-1:0]    a, b;
    logic [4:0]         shamt;
    logic [XLEN-1:0]    result;
    logic               cdb_valid_q;
    logic [TAG_LEN-1:0] cdb_tag_q;
    logic [XLEN-1:0]    cdb_value_q;

    assign a     = issue.opa.value;
    assign b     = issue.opb.value;
    assign shamt = b[4:0];

    always_comb begin
        case (issue.alu_func)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);  // sign fill
            default:  result = '0;
        endcase
    end

    ////////////////////
    // broadcast register
    always_ff @(posedge clock) begin
        if (rst || commit_mis_pred)
            cdb_valid_q <= 1'b0;
        else
            cdb_valid_q <= issue_valid;
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            cdb_tag_q   <= issue.dest_tag;
            cdb_value_q <= result;
        end
    end

    assign cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};

endmodule

//--- logic/alu_cluster_top.sv
////////////////////
// ALU cluster top, select -> station -> alu
// cdb loops back to the station for wakeup
// caller must hold dispatch while rs_full
////////////////////

`timescale 1ns/1ps

module alu_cluster_top import ooo_pkg::*; (
    input  logic             clock,
    input  logic             rst,
    input  logic             commit_mis_pred,
    input  dispatch_packet_t dispatch,
    output logic             rs_full,
    output cdb_packet_t      cdb
);

    rs_entry_t entry_in;        // select -> station
    logic      dispatch_valid;
    rs_entry_t issue;           // station -> alu
    logic      issue_valid;

    operand_select u_operand_select (
        .dispatch       (dispatch),
        .entry_in       (entry_in),
        .dispatch_valid (dispatch_valid)
    );

    rs_alu u_rs_alu (
        .clock           (clock),
        .rst             (rst),
        .commit_mis_pred (commit_mis_pred),
        .dispatch_valid  (dispatch_valid),
        .entry_in        (entry_in),
        .cdb             (cdb),           // wakeup loop
        .issue           (issue),
        .issue_valid     (issue_valid),
        .rs_full         (rs_full)
    );

    alu_stage u_alu_stage (
        .clock           (clock),
        .rst             (rst),
        .commit_mis_pred (commit_mis_pred),
        .issue           (issue),
        .issue_valid     (issue_valid),
        .cdb             (cdb)
    );

endmodule

//--- testbench/tb_clock.sv
////////////////////
// clock and reset source, 8 ns period
// rst high for the first 4 rising edges
////////////////////

`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clock);
        rst <= 1'b0;  // released on an edge, like the stimulus
    end

endmodule

//--- testbench/alu_cluster_checker.sv
////////////////////
// protocol assertions for rs_alu, attached by bind
// needs the simulator's assertion support enabled
////////////////////

`timescale 1ns/1ps

module alu_cluster_checker (
    input logic clock,
    input logic rst,
    input logic commit_mis_pred,
    input logic dispatch_valid,
    input logic rs_full,
    input logic issue_valid
);

    // a dispatch into a full station is silently lost
    a_no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (rst) !(dispatch_valid && rs_full)
    ) else $error("dispatch presented while station is full");

    // flush kills the issue register
    a_flush_clears_issue: assert property (
        @(posedge clock) disable iff (rst) commit_mis_pred |=> !issue_valid
    ) else $error("issue_valid high in the cycle after a flush");

    a_reset_empties: assert property (
        @(posedge clock) rst |=> !rs_full
    ) else $error("rs_full high after reset");

endmodule

bind rs_alu alu_cluster_checker u_checker (.*);

//--- testbench/tb_monitor.sv
////////////////////
// reference model and CDB scoreboard
// results matched by tag, order of broadcasts is free
// dest tags must be unique over a run
////////////////////

`timescale 1ns/1ps

module tb_monitor import ooo_pkg::*; (
    input  logic             clock,
    input  logic             rst,
    input  dispatch_packet_t dispatch,
    input  logic             expect_result,  // 0 for rows killed by a flush
    input  logic             rs_full,
    input  cdb_packet_t      cdb,
    output int               mismatch_count,
    output int               stray_count,
    output int               protocol_count,
    output int               outstanding      // expected tags not yet seen
);

    logic [XLEN-1:0] model_val [64];  // expected value per tag
    logic            pending   [64];  // dispatched, not yet broadcast
    logic            live      [64];  // should broadcast
    logic            seen_dispatch;
    logic [XLEN-1:0] op_a, op_b;

    function automatic logic [XLEN-1:0] src_value(input operand_t op);
        return op.ready ? op.value : model_val[op.tag];  // value of the producer row
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(input alu_func_t f,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        logic [4:0]      sh;
        sh = b[4:0];
        case (f)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 32'd1;  // two's complement
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA: begin
                r = a >> sh;
                if (a[31])
                    r = r | ~(32'hffff_ffff >> sh);  // refill sign bits
            end
            default:  r = '0;
        endcase
        return r;
    endfunction

    always @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                model_val[i] = '0;
                pending[i]   = 1'b0;
                live[i]      = 1'b0;
            end
            seen_dispatch  = 1'b0;
            mismatch_count = 0;
            stray_count    = 0;
            protocol_count = 0;
            outstanding    = 0;
        end else begin
            // quiet station until the first dispatch
            if (!seen_dispatch && (rs_full || cdb.valid)) begin
                $display("time %0t: rs_full or cdb.valid high before any dispatch", $time);
                protocol_count++;
            end
            ////////////////////
            // broadcast side
            if (cdb.valid) begin
                if (!pending[cdb.tag]) begin
                    $display("time %0t: broadcast of unknown tag %0d", $time, cdb.tag);
                    stray_count++;
                end else if (!live[cdb.tag]) begin
                    $display("time %0t: broadcast of flushed tag %0d", $time, cdb.tag);
                    stray_count++;
                    pending[cdb.tag] = 1'b0;
                end else begin
                    if (cdb.value !== model_val[cdb.tag]) begin
                        $display("MISMATCH time %0t: cdb.value tag %0d expected %h got %h",
                                 $time, cdb.tag, model_val[cdb.tag], cdb.value);
                        mismatch_count++;
                    end
                    pending[cdb.tag] = 1'b0;  // second broadcast counts as stray
                    outstanding--;
                end
            end
            ////////////////////
            // dispatch side
            if (dispatch.valid) begin
                seen_dispatch = 1'b1;
                if (rs_full) begin
                    $display("time %0t: dispatch of tag %0d lost, station full",
                             $time, dispatch.dest_tag);
                    protocol_count++;
                end else begin
                    case (dispatch.opa_select)
                        OPA_IS_RS1: op_a = src_value(dispatch.rs1);
                        OPA_IS_PC:  op_a = dispatch.pc;
                        OPA_IS_NPC: op_a = dispatch.npc;
                        default:    op_a = '0;
                    endcase
                    case (dispatch.opb_select)
                        OPB_IS_RS2:   op_b = src_value(dispatch.rs2);
                        OPB_IS_I_IMM: op_b = 32'($signed(dispatch.inst[31:20]));
                        OPB_IS_U_IMM: op_b = {dispatch.inst[31:12], 12'h000};
                        default:      op_b = '0;
                    endcase
                    model_val[dispatch.dest_tag] = ref_alu(dispatch.alu_func, op_a, op_b);
                    pending[dispatch.dest_tag]   = 1'b1;
                    live[dispatch.dest_tag]      = expect_result;
                    if (expect_result)
                        outstanding++;
                end
            end
        end
    end

endmodule

//--- testbench/tb_top.sv
////////////////////
// testbench top for the ALU cluster
// stimulus table built at time zero, then applied one row per edge
// hold rows wait for a free station entry, others are timed by the table
////////////////////

`timescale 1ns/1ps

module tb_top import ooo_pkg::*;;

    logic             clock, rst;
    logic             commit_mis_pred;
    logic             dispatch_expect;
    dispatch_packet_t dispatch;
    logic             rs_full;
    cdb_packet_t      cdb;
    int               mismatch_count, stray_count, protocol_count, outstanding;

    // stimulus table, one entry per row
    dispatch_packet_t tbl_pkt[$];
    logic             tbl_exp[$];
    logic             tbl_hold[$];
    logic             tbl_flush[$];

    int         seed;
    logic [5:0] next_tag = 6'd1;  // tag 0 means constant
    logic [5:0] t, ta, tb, tc;
    int         cycle_count = 0;
    int         cycle_limit = 1000000;
    int         tb_errors = 0;
    logic       full_seen = 1'b0;

    tb_clock u_clock (.clock(clock), .rst(rst));

    alu_cluster_top DUT (
        .clock           (clock),
        .rst             (rst),
        .commit_mis_pred (commit_mis_pred),
        .dispatch        (dispatch),
        .rs_full         (rs_full),
        .cdb             (cdb)
    );

    tb_monitor u_monitor (
        .clock(clock), .rst(rst), .dispatch(dispatch), .expect_result(dispatch_expect),
        .rs_full(rs_full), .cdb(cdb), .mismatch_count(mismatch_count),
        .stray_count(stray_count), .protocol_count(protocol_count), .outstanding(outstanding)
    );

    function automatic operand_t reg_op(input logic [XLEN-1:0] v);
        operand_t op;
        op.tag   = '0;
        op.ready = 1'b1;
        op.value = v;
        return op;
    endfunction

    function automatic operand_t wait_op(input logic [5:0] tag);
        operand_t op;
        op.tag   = tag;
        op.ready = 1'b0;
        op.value = 32'hdead_beef;  // must be replaced by wakeup
        return op;
    endfunction

    task automatic add_op(input alu_func_t f, input opa_select_t sa, input opb_select_t sb,
                          input operand_t r1, input operand_t r2, input logic [31:0] inst,
                          input logic [31:0] pc, input logic keep, input logic hold,
                          input logic flush, output logic [5:0] tag);
        dispatch_packet_t p;
        p            = '0;
        p.valid      = 1'b1;
        p.inst       = inst;
        p.pc         = pc;
        p.npc        = pc + 32'd4;
        p.opa_select = sa;
        p.opb_select = sb;
        p.alu_func   = f;
        p.rs1        = r1;
        p.rs2        = r2;
        tag          = next_tag;
        next_tag     = next_tag + 6'd1;
        p.dest_tag   = tag;
        tbl_pkt.push_back(p);
        tbl_exp.push_back(keep);
        tbl_hold.push_back(hold);
        tbl_flush.push_back(flush);
    endtask

    // both operands ready from registers
    task automatic add_rr(input alu_func_t f, input logic [31:0] a, input logic [31:0] b,
                          output logic [5:0] tag);
        add_op(f, OPA_IS_RS1, OPB_IS_RS2, reg_op(a), reg_op(b), '0, 32'h100, 1'b1, 1'b0,
               1'b0, tag);
    endtask

    task automatic add_idle(input int n);
        repeat (n) begin
            tbl_pkt.push_back('0);
            tbl_exp.push_back(1'b0);
            tbl_hold.push_back(1'b0);
            tbl_flush.push_back(1'b0);
        end
    endtask

    task automatic build_table();
        add_idle(3);  // quiet after reset
        ////////////////////
        // every function, random operands
        for (int f = 0; f < 10; f++)
            add_rr(alu_func_t'(4'(f)), $random(seed), $random(seed), t);
        add_rr(ALU_SLT, 32'hffff_fff0, 32'd5, t);   // negative vs positive
        add_rr(ALU_SLTU, 32'hffff_fff0, 32'd5, t);
        add_rr(ALU_SLL, 32'h1234_5679, 32'hffff_ffff, t);  // shamt 31
        add_rr(ALU_SRL, 32'h8000_0001, 32'd63, t);
        add_rr(ALU_SRA, 32'h8000_0000, 32'd31, t);
        ////////////////////
        // operand sources and immediates
        add_op(ALU_ADD, OPA_IS_PC, OPB_IS_I_IMM, reg_op(0), reg_op(0), {12'h123, 20'h0},
               32'h0000_1000, 1'b1, 1'b0, 1'b0, t);
        add_op(ALU_ADD, OPA_IS_NPC, OPB_IS_I_IMM, reg_op(0), reg_op(0), {12'hff8, 20'h0},
               32'h0000_2000, 1'b1, 1'b0, 1'b0, t);  // negative imm
        add_op(ALU_ADD, OPA_IS_ZERO, OPB_IS_U_IMM, reg_op(7), reg_op(0), {20'habcde, 12'h5a3},
               32'h0000_3000, 1'b1, 1'b0, 1'b0, t);
        add_op(ALU_ADD, OPA_IS_PC, OPB_IS_U_IMM, reg_op(0), reg_op(0), {20'h00010, 12'hfff},
               32'h0000_4004, 1'b1, 1'b0, 1'b0, t);
        add_op(ALU_XOR, OPA_IS_RS1, OPB_IS_I_IMM, reg_op($random(seed)), reg_op(0),
               {12'h801, 20'h0}, 32'h0000_5000, 1'b1, 1'b0, 1'b0, t);
        ////////////////////
        // dependent chains
        add_rr(ALU_ADD, $random(seed), $random(seed), ta);
        add_op(ALU_SUB, OPA_IS_RS1, OPB_IS_RS2, wait_op(ta), reg_op($random(seed)), '0,
               32'h200, 1'b1, 1'b0, 1'b0, tb);
        add_op(ALU_XOR, OPA_IS_RS1, OPB_IS_RS2, wait_op(tb), wait_op(ta), '0,
               32'h204, 1'b1, 1'b0, 1'b0, t);
        add_idle(4);
        add_rr(ALU_OR, $random(seed), $random(seed), ta);
        add_idle(2);  // consumer lands on the producer's broadcast cycle
        add_op(ALU_ADD, OPA_IS_RS1, OPB_IS_I_IMM, wait_op(ta), reg_op(0), {12'h007, 20'h0},
               32'h208, 1'b1, 1'b0, 1'b0, t);
        add_idle(6);
        ////////////////////
        // back-pressure, slow producer chain then five consumers
        add_rr(ALU_ADD, 32'd10, 32'd5, ta);
        add_op(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, wait_op(ta), reg_op(1), '0, 32'h300,
               1'b1, 1'b0, 1'b0, tb);
        add_op(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, wait_op(tb), reg_op(1), '0, 32'h304,
               1'b1, 1'b0, 1'b0, tc);
        add_op(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, wait_op(tc), reg_op(1), '0, 32'h308,
               1'b1, 1'b0, 1'b0, ta);  // producer, value 18
        add_op(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, wait_op(ta), reg_op(100), '0, 32'h30c,
               1'b1, 1'b0, 1'b0, t);
        add_op(ALU_SUB, OPA_IS_RS1, OPB_IS_RS2, wait_op(ta), reg_op(3), '0, 32'h310,
               1'b1, 1'b0, 1'b0, t);
        add_op(ALU_SLL, OPA_IS_RS1, OPB_IS_RS2, reg_op(1), wait_op(ta), '0, 32'h314,
               1'b1, 1'b1, 1'b0, t);
        // late consumers read the producer value from the register file
        add_rr(ALU_XOR, 32'd18, 32'hff, t);
        tbl_hold[tbl_hold.size() - 1] = 1'b1;
        add_rr(ALU_OR, 32'd18, 32'h100, t);
        tbl_hold[tbl_hold.size() - 1] = 1'b1;
        add_idle(8);
        ////////////////////
        // flush, nothing before or during it may broadcast
        tc = next_tag + 6'd4;  // dest tag of the first row after the flush
        add_op(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, wait_op(tc), reg_op(1), '0, 32'h400,
               1'b0, 1'b0, 1'b0, t);  // would wake on the post-flush producer
        add_op(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, reg_op(2), reg_op(32'd9), '0, 32'h404,
               1'b0, 1'b0, 1'b0, t);  // in the ALU at the flush edge
        add_op(ALU_AND, OPA_IS_RS1, OPB_IS_RS2, reg_op(32'hf0), reg_op(32'h3c), '0, 32'h408,
               1'b0, 1'b0, 1'b0, t);  // ready, killed in issue
        add_op(ALU_OR, OPA_IS_RS1, OPB_IS_RS2, reg_op(4), reg_op(8), '0, 32'h40c,
               1'b0, 1'b0, 1'b1, t);  // dispatched with the flush
        add_rr(ALU_ADD, $random(seed), $random(seed), ta);
        add_rr(ALU_SLTU, $random(seed), $random(seed), t);
        add_op(ALU_SRA, OPA_IS_RS1, OPB_IS_RS2, wait_op(ta), reg_op(32'd4), '0, 32'h410,
               1'b1, 1'b0, 1'b0, t);
        add_idle(2);
    endtask

    // station full seen at least once
    always @(negedge clock) begin
        if (rs_full === 1'b1)
            full_seen <= 1'b1;
    end

    // run limit from the table length
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d results still missing",
                     cycle_count, outstanding);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        dispatch        = '0;
        commit_mis_pred = 1'b0;
        dispatch_expect = 1'b0;
        seed            = 32'h3ec;
        build_table();
        cycle_limit = 20 * tbl_pkt.size() + 50;
        while (rst !== 1'b0)
            @(posedge clock);
        for (int i = 0; i < tbl_pkt.size(); i++) begin
            if (tbl_hold[i]) begin
                @(posedge clock);
                dispatch        <= '0;  // idle slot, so rs_full can only fall
                dispatch_expect <= 1'b0;
                commit_mis_pred <= 1'b0;
                @(negedge clock);
                while (rs_full)
                    @(negedge clock);
            end
            @(posedge clock);
            dispatch        <= tbl_pkt[i];
            dispatch_expect <= tbl_exp[i];
            commit_mis_pred <= tbl_flush[i];
        end
        @(posedge clock);
        dispatch        <= '0;
        dispatch_expect <= 1'b0;
        commit_mis_pred <= 1'b0;
        @(negedge clock);
        while (outstanding != 0)
            @(negedge clock);
        repeat (10) @(posedge clock);  // catch late or repeated broadcasts
        if (!full_seen) begin
            $display("station never reported full during the back-pressure rows");
            tb_errors++;
        end
        $display("errors: mismatch %0d, stray %0d, protocol %0d, missing %0d, other %0d",
                 mismatch_count, stray_count, protocol_count, outstanding, tb_errors);
        if (mismatch_count + stray_count + protocol_count + outstanding + tb_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- tb.f
logic/ooo_pkg.sv
logic/operand_select.sv
logic/rs_alu.sv
logic/alu_stage.sv
logic/alu_cluster_top.sv
testbench/tb_clock.sv
testbench/alu_cluster_checker.sv
testbench/tb_monitor.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ALU cluster testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_top --Mdir obj_dir -o Vsim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "** FAIL **" "$LOG"; then
    exit 1
fi
if ! grep -qF "** PASS **" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi
exit 0
